// File: hw/fc_accel_cfg.svh
`ifndef FC_ACCEL_CFG_SVH
`define FC_ACCEL_CFG_SVH

// Datapath widths
`define DWIDTH   16
`define BWIDTH   32
`define LWIDTH   10
`define AWIDTH   40

// Fractional bits of the fixed-point format
`define QBITS    8

// Memory address widths
`define IMGSIZE  10
`define NETSIZE  10

// Register map
`define REGSIZE         4
`define REG_REQ         0
`define REG_IN_OFFSET   1
`define REG_OUT_OFFSET  2
`define REG_NET_OFFSET  3
`define REG_BASE        4
`define REG_ACTV        5
`define REG_STATUS      8

// Enable bits inside REG_ACTV
`define ACTV_RELU_BIT   31
`define ACTV_BIAS_BIT   30

`endif

// File: hw/fc_accel_pkg.sv
`default_nettype none

`include "fc_accel_cfg.svh"

package fc_accel_pkg;

  // Host memory address covers the larger of the two memories
  localparam int MADDR = (`IMGSIZE > `NETSIZE) ? `IMGSIZE : `NETSIZE;

  typedef struct packed {
    logic                we;
    logic                re;
    logic [`REGSIZE-1:0] idx;
    logic [`BWIDTH-1:0]  wdata;
  } reg_req_t;

  // sel_net set targets the weight memory
  typedef struct packed {
    logic               we;
    logic               re;
    logic               sel_net;
    logic [MADDR-1:0]   addr;
    logic [`DWIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`IMGSIZE-1:0] in_offset;
    logic [`IMGSIZE-1:0] out_offset;
    logic [`NETSIZE-1:0] net_offset;
    logic [`LWIDTH-1:0]  total_out;
    logic [`LWIDTH-1:0]  total_in;
    logic                bias_en;
    logic                relu_en;
  } layer_cfg_t;

  // Layer shape view of the BASE word
  typedef struct packed {
    logic [`BWIDTH-16-`LWIDTH-1:0] rsvd_hi;
    logic [`LWIDTH-1:0]            total_out;
    logic [16-`LWIDTH-1:0]         rsvd_lo;
    logic [`LWIDTH-1:0]            total_in;
  } base_shape_t;

  typedef union packed {
    logic [`BWIDTH-1:0] raw;
    base_shape_t        shape;
  } base_word_u;

  typedef struct packed {
    logic                valid;
    logic                first;
    logic                last;
    logic                is_bias;
    logic [`IMGSIZE-1:0] out_addr;
  } mac_tag_t;

  typedef struct packed {
    logic                valid;
    logic [`IMGSIZE-1:0] addr;
    logic [`DWIDTH-1:0]  data;
  } img_wr_t;

endpackage

`default_nettype wire

// File: hw/param_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module param_regs (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire fc_accel_pkg::reg_req_t  host_reg,
  input  wire                          busy,
  input  wire                          done,
  output logic [`BWIDTH-1:0]           reg_rdata,
  output logic                         reg_rvalid,
  output fc_accel_pkg::layer_cfg_t     cfg,
  output logic                         start
);
  import fc_accel_pkg::*;

  logic [`IMGSIZE-1:0] in_offset_q;
  logic [`IMGSIZE-1:0] out_offset_q;
  logic [`NETSIZE-1:0] net_offset_q;
  base_word_u          base_q;
  logic                bias_en_q;
  logic                relu_en_q;
  logic                wr_open;
  logic                req_hit;
  logic [`BWIDTH-1:0]  actv_word;

  // Layer registers stay frozen from the start pulse until idle again
  assign wr_open = host_reg.we && !busy && !start;
  assign req_hit = wr_open && host_reg.idx == `REG_REQ && host_reg.wdata[0];

  //========================================
  // Host writes
  //========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_offset_q  <= '0;
      out_offset_q <= '0;
      net_offset_q <= '0;
      base_q.raw   <= '0;
      bias_en_q    <= 1'b0;
      relu_en_q    <= 1'b0;
    end else if (wr_open) begin
      case (host_reg.idx)
        `REG_IN_OFFSET:  in_offset_q  <= host_reg.wdata[`IMGSIZE-1:0];
        `REG_OUT_OFFSET: out_offset_q <= host_reg.wdata[`IMGSIZE-1:0];
        `REG_NET_OFFSET: net_offset_q <= host_reg.wdata[`NETSIZE-1:0];
        `REG_BASE:       base_q.raw   <= host_reg.wdata;
        `REG_ACTV: begin
          relu_en_q <= host_reg.wdata[`ACTV_RELU_BIT];
          bias_en_q <= host_reg.wdata[`ACTV_BIAS_BIT];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start <= 1'b0;
    end else begin
      start <= req_hit;
    end
  end

  //========================================
  // Host reads
  //========================================
  always_comb begin
    actv_word                 = '0;
    actv_word[`ACTV_RELU_BIT] = relu_en_q;
    actv_word[`ACTV_BIAS_BIT] = bias_en_q;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= host_reg.re;
    end
  end

  always_ff @(posedge clk) begin
    if (host_reg.re) begin
      case (host_reg.idx)
        `REG_IN_OFFSET:  reg_rdata <= `BWIDTH'(in_offset_q);
        `REG_OUT_OFFSET: reg_rdata <= `BWIDTH'(out_offset_q);
        `REG_NET_OFFSET: reg_rdata <= `BWIDTH'(net_offset_q);
        `REG_BASE:       reg_rdata <= base_q.raw;
        `REG_ACTV:       reg_rdata <= actv_word;
        // Bit 0 done, bit 1 busy
        `REG_STATUS:     reg_rdata <= `BWIDTH'({busy, done});
        default:         reg_rdata <= '0;
      endcase
    end
  end

  always_comb begin
    cfg.in_offset  = in_offset_q;
    cfg.out_offset = out_offset_q;
    cfg.net_offset = net_offset_q;
    cfg.total_out  = base_q.shape.total_out;
    cfg.total_in   = base_q.shape.total_in;
    cfg.bias_en    = bias_en_q;
    cfg.relu_en    = relu_en_q;
  end

endmodule

`default_nettype wire

// File: hw/img_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module img_buf (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire fc_accel_pkg::mem_req_t  host_mem,
  input  wire                          busy,
  input  wire [`IMGSIZE-1:0]           core_raddr,
  input  wire fc_accel_pkg::img_wr_t   img_wr,
  output logic [`DWIDTH-1:0]           core_rdata,
  output logic [`DWIDTH-1:0]           mem_rdata,
  output logic                         mem_rvalid
);

  logic [`DWIDTH-1:0]  mem [0:2**`IMGSIZE-1];
  logic                we;
  logic [`IMGSIZE-1:0] waddr;
  logic [`DWIDTH-1:0]  wdata;
  logic [`IMGSIZE-1:0] raddr;
  logic [`DWIDTH-1:0]  rdata_q;
  logic                host_zero_q;

  // The core owns both ports while busy
  assign we    = busy ? img_wr.valid : host_mem.we && !host_mem.sel_net;
  assign waddr = busy ? img_wr.addr : host_mem.addr[`IMGSIZE-1:0];
  assign wdata = busy ? img_wr.data : host_mem.wdata;
  assign raddr = busy ? core_raddr : host_mem.addr[`IMGSIZE-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata_q     <= mem[raddr];
    host_zero_q <= busy || host_mem.sel_net;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_rvalid <= 1'b0;
    end else begin
      mem_rvalid <= host_mem.re;
    end
  end

  assign core_rdata = rdata_q;
  // Weight reads and reads during a run return zero
  assign mem_rdata  = host_zero_q ? '0 : rdata_q;

endmodule

`default_nettype wire

// File: hw/net_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module net_mem (
  input  wire                          clk,
  input  wire fc_accel_pkg::mem_req_t  host_mem,
  input  wire [`NETSIZE-1:0]           net_raddr,
  output logic [`DWIDTH-1:0]           net_rdata
);

  logic [`DWIDTH-1:0]  mem [0:2**`NETSIZE-1];
  logic                we;
  logic [`NETSIZE-1:0] waddr;

  // Weights and biases share one array, rows laid out by the host
  assign we    = host_mem.we && host_mem.sel_net;
  assign waddr = host_mem.addr[`NETSIZE-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= host_mem.wdata;
    end
  end

  always_ff @(posedge clk) begin
    net_rdata <= mem[net_raddr];
  end

endmodule

`default_nettype wire

// File: hw/fc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module fc_ctrl (
  input  wire                            clk,
  input  wire                            xrst,
  input  wire                            start,
  input  wire fc_accel_pkg::layer_cfg_t  cfg,
  output logic [`IMGSIZE-1:0]            img_raddr,
  output logic [`NETSIZE-1:0]            net_raddr,
  output fc_accel_pkg::mac_tag_t         tag,
  output logic                           busy,
  output logic                           done
);
  import fc_accel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_DRAIN
  } state_t;

  // Memory read, product register and accumulator
  localparam logic [1:0] DRAIN_LAST = 2'd2;

  state_t              state;
  logic [`LWIDTH-1:0]  in_cnt;
  logic [`LWIDTH-1:0]  out_cnt;
  logic [`NETSIZE-1:0] row_base;
  logic [1:0]          drain_cnt;
  logic [`LWIDTH-1:0]  row_last;
  logic                in_last;
  logic                out_last;
  logic                empty;
  mac_tag_t            tag_d;

  // With bias on, each row ends with one extra weight read
  assign row_last = cfg.bias_en ? cfg.total_in : cfg.total_in - 1'b1;
  assign in_last  = in_cnt == row_last;
  assign out_last = out_cnt == cfg.total_out - 1'b1;
  assign empty    = cfg.total_out == '0 || (cfg.total_in == '0 && !cfg.bias_en);

  assign img_raddr = cfg.in_offset + `IMGSIZE'(in_cnt);
  assign net_raddr = row_base + `NETSIZE'(in_cnt);
  assign busy      = state != S_IDLE;

  always_comb begin
    tag_d.valid    = state == S_RUN;
    tag_d.first    = in_cnt == '0;
    tag_d.last     = in_last;
    tag_d.is_bias  = cfg.bias_en && in_cnt == cfg.total_in;
    tag_d.out_addr = cfg.out_offset + `IMGSIZE'(out_cnt);
  end

  //========================================
  // Sequencer
  //========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_IDLE;
      done      <= 1'b0;
      in_cnt    <= '0;
      out_cnt   <= '0;
      row_base  <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            done      <= 1'b0;
            in_cnt    <= '0;
            out_cnt   <= '0;
            row_base  <= cfg.net_offset;
            drain_cnt <= '0;
            state     <= empty ? S_DRAIN : S_RUN;
          end
        end
        S_RUN: begin
          if (in_last) begin
            in_cnt   <= '0;
            row_base <= row_base + `NETSIZE'(in_cnt) + 1'b1;
            out_cnt  <= out_cnt + 1'b1;
            if (out_last) begin
              state <= S_DRAIN;
            end
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        S_DRAIN: begin
          // Last result write lands in the final drain cycle
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_LAST) begin
            state <= S_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Tag follows its operands through the one-cycle memory read
  always_ff @(posedge clk) begin
    if (!xrst) begin
      tag <= '0;
    end else begin
      tag <= tag_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/fc_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module fc_mac (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire fc_accel_pkg::mac_tag_t  tag,
  input  wire [`DWIDTH-1:0]            img_rdata,
  input  wire [`DWIDTH-1:0]            net_rdata,
  input  wire                          relu_en,
  output fc_accel_pkg::img_wr_t        img_wr
);
  import fc_accel_pkg::*;

  localparam logic signed [`AWIDTH-1:0] SAT_MAX = 2**(`DWIDTH-1) - 1;
  localparam logic signed [`AWIDTH-1:0] SAT_MIN = -(2**(`DWIDTH-1));

  logic signed [2*`DWIDTH-1:0] mult;
  logic signed [`AWIDTH-1:0]   bias_term;
  logic signed [`AWIDTH-1:0]   prod_q;
  logic signed [`AWIDTH-1:0]   acc_q;
  logic signed [`AWIDTH-1:0]   shifted;
  logic signed [`DWIDTH-1:0]   sat;
  logic [`DWIDTH-1:0]          result;
  mac_tag_t                    tag_mul;
  mac_tag_t                    tag_acc;

  assign mult      = $signed(img_rdata) * $signed(net_rdata);
  // Bias is aligned to the product's fixed point
  assign bias_term = `AWIDTH'($signed(net_rdata)) <<< `QBITS;

  //========================================
  // Multiply and accumulate
  //========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      tag_mul <= '0;
      tag_acc <= '0;
    end else begin
      tag_mul <= tag;
      tag_acc <= tag_mul;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      prod_q <= tag.is_bias ? bias_term : `AWIDTH'(mult);
    end
    if (tag_mul.valid) begin
      acc_q <= tag_mul.first ? prod_q : acc_q + prod_q;
    end
  end

  //========================================
  // Rounding down, saturation and ReLU
  //========================================
  assign shifted = acc_q >>> `QBITS;

  always_comb begin
    if (shifted > SAT_MAX) begin
      sat = SAT_MAX[`DWIDTH-1:0];
    end else if (shifted < SAT_MIN) begin
      sat = SAT_MIN[`DWIDTH-1:0];
    end else begin
      sat = shifted[`DWIDTH-1:0];
    end
    result = (relu_en && sat[`DWIDTH-1]) ? '0 : sat;
  end

  always_comb begin
    img_wr.valid = tag_acc.valid && tag_acc.last;
    img_wr.addr  = tag_acc.out_addr;
    img_wr.data  = result;
  end

endmodule

`default_nettype wire

// File: hw/fc_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module fc_accel_top (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire fc_accel_pkg::reg_req_t  host_reg,
  output logic [`BWIDTH-1:0]           reg_rdata,
  output logic                         reg_rvalid,
  input  wire fc_accel_pkg::mem_req_t  host_mem,
  output logic [`DWIDTH-1:0]           mem_rdata,
  output logic                         mem_rvalid
);
  import fc_accel_pkg::*;

  layer_cfg_t          cfg;
  logic                start;
  logic                busy;
  logic                done;
  logic [`IMGSIZE-1:0] img_raddr;
  logic [`NETSIZE-1:0] net_raddr;
  logic [`DWIDTH-1:0]  img_rdata;
  logic [`DWIDTH-1:0]  net_rdata;
  mac_tag_t            tag;
  img_wr_t             img_wr;

  //========================================
  // Control
  //========================================
  param_regs i_regs (
    .clk        (clk),
    .xrst       (xrst),
    .host_reg   (host_reg),
    .busy       (busy),
    .done       (done),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .cfg        (cfg),
    .start      (start)
  );

  fc_ctrl i_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .img_raddr (img_raddr),
    .net_raddr (net_raddr),
    .tag       (tag),
    .busy      (busy),
    .done      (done)
  );

  //========================================
  // Datapath and memories
  //========================================
  fc_mac i_mac (
    .clk       (clk),
    .xrst      (xrst),
    .tag       (tag),
    .img_rdata (img_rdata),
    .net_rdata (net_rdata),
    .relu_en   (cfg.relu_en),
    .img_wr    (img_wr)
  );

  img_buf i_img_buf (
    .clk        (clk),
    .xrst       (xrst),
    .host_mem   (host_mem),
    .busy       (busy),
    .core_raddr (img_raddr),
    .img_wr     (img_wr),
    .core_rdata (img_rdata),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid)
  );

  net_mem i_net_mem (
    .clk       (clk),
    .host_mem  (host_mem),
    .net_raddr (net_raddr),
    .net_rdata (net_rdata)
  );

endmodule

`default_nettype wire

// File: test/tb_fc_accel.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_accel_cfg.svh"

module tb_fc_accel;
  import fc_accel_pkg::*;

  localparam int CLK_HALF  = 20;
  localparam int DRIVE_DLY = 2;
  localparam int MAX_POLLS = 200;

  // Layer A plain, layer B with bias and ReLU, layer C reuses A's inputs
  localparam int A_IN   = 8;
  localparam int A_OUT  = 6;
  localparam int A_IOFF = 0;
  localparam int A_OOFF = 100;
  localparam int A_NOFF = 0;
  localparam int B_IN   = 10;
  localparam int B_OUT  = 5;
  localparam int B_IOFF = 200;
  localparam int B_OOFF = 300;
  localparam int B_NOFF = 100;
  localparam int C_OUT  = 3;
  localparam int C_OOFF = 600;
  localparam int C_NOFF = 300;

  localparam int WORK = A_OUT * (A_IN + 1) + B_OUT * (B_IN + 2) + C_OUT * (A_IN + 1);
  localparam int TIMEOUT_CYCLES = 20 * WORK + 2000;

  logic               clk = 1'b0;
  logic               xrst;
  reg_req_t           host_reg;
  logic [`BWIDTH-1:0] reg_rdata;
  logic               reg_rvalid;
  mem_req_t           host_mem;
  logic [`DWIDTH-1:0] mem_rdata;
  logic               mem_rvalid;

  logic [31:0] rng_state = 32'd31668;
  logic        reg_re_q  = 1'b0;
  logic        mem_re_q  = 1'b0;

  // Host view of both memories, plus the outputs the model expects
  logic signed [`DWIDTH-1:0] img_model [0:2**`IMGSIZE-1];
  logic signed [`DWIDTH-1:0] net_model [0:2**`NETSIZE-1];

  always #CLK_HALF clk = ~clk;

  fc_accel_top i_dut (
    .clk        (clk),
    .xrst       (xrst),
    .host_reg   (host_reg),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .host_mem   (host_mem),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid)
  );

  //========================================
  // Failure reporting and checks
  //========================================
  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, exp, got);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    value_match: assert (got === exp)
      else report_mismatch(name, exp, got);
  endtask

  always @(posedge clk) begin
    reg_re_q <= host_reg.re;
    mem_re_q <= host_mem.re;
  end

  // Read valids answer each request exactly one cycle later
  reg_rvalid_latency: assert property (@(posedge clk) disable iff (!xrst)
    reg_rvalid == reg_re_q)
    else report_mismatch("reg_rvalid", $sampled(reg_re_q), $sampled(reg_rvalid));

  mem_rvalid_latency: assert property (@(posedge clk) disable iff (!xrst)
    mem_rvalid == mem_re_q)
    else report_mismatch("mem_rvalid", $sampled(mem_re_q), $sampled(mem_rvalid));

  core_write_in_run: assert property (@(posedge clk) disable iff (!xrst)
    i_dut.img_wr.valid |-> i_dut.busy)
    else abort_run("core wrote the image buffer while the engine was idle");

  //========================================
  // Stimulus helpers
  //========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    rng_state = xorshift32(rng_state);
    return lo + int'(rng_state % 32'(hi - lo + 1));
  endfunction

  task automatic next_slot;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic reg_write(input int idx, input logic [31:0] data);
    host_reg.we    = 1'b1;
    host_reg.idx   = `REGSIZE'(idx);
    host_reg.wdata = data;
    next_slot();
    host_reg = '0;
  endtask

  task automatic reg_read(input int idx, output logic [31:0] data);
    host_reg.re  = 1'b1;
    host_reg.idx = `REGSIZE'(idx);
    next_slot();
    host_reg = '0;
    data = reg_rdata;
  endtask

  task automatic mem_write(input bit sel_net, input int addr, input logic [`DWIDTH-1:0] data);
    host_mem.we      = 1'b1;
    host_mem.sel_net = sel_net;
    host_mem.addr    = MADDR'(addr);
    host_mem.wdata   = data;
    if (sel_net) begin
      net_model[addr] = data;
    end else begin
      img_model[addr] = data;
    end
    next_slot();
    host_mem = '0;
  endtask

  task automatic mem_read(input bit sel_net, input int addr, output logic [`DWIDTH-1:0] data);
    host_mem.re      = 1'b1;
    host_mem.sel_net = sel_net;
    host_mem.addr    = MADDR'(addr);
    next_slot();
    host_mem = '0;
    data = mem_rdata;
  endtask

  task automatic wait_done;
    logic [`BWIDTH-1:0] status;
    int                 polls;
    status = '0;
    polls  = 0;
    while (!status[0] && polls < MAX_POLLS) begin
      reg_read(`REG_STATUS, status);
      polls++;
    end
    if (!status[0]) begin
      abort_run("engine did not raise done within the poll limit");
    end
    check_value("status", 32'h1, status);
  endtask

  task automatic verify_area(input int off, input int n);
    logic [`DWIDTH-1:0] got;
    logic [`DWIDTH-1:0] exp;
    for (int i = 0; i < n; i++) begin
      exp = img_model[off + i];
      mem_read(1'b0, off + i, got);
      check_value("mem_rdata", 32'(exp), 32'(got));
    end
  endtask

  //========================================
  // Reference model and layer runs
  //========================================
  function automatic logic [`DWIDTH-1:0] model_output(input int n_in, input int in_off,
                                                     input int row_base, input bit bias_en,
                                                     input bit relu_en);
    longint acc;
    longint res;
    acc = 0;
    for (int i = 0; i < n_in; i++) begin
      acc += longint'(img_model[in_off + i]) * longint'(net_model[row_base + i]);
    end
    if (bias_en) begin
      acc += longint'(net_model[row_base + n_in]) <<< `QBITS;
    end
    res = acc >>> `QBITS;
    if (res > 32767) res = 32767;
    if (res < -32768) res = -32768;
    if (relu_en && res < 0) res = 0;
    return res[`DWIDTH-1:0];
  endfunction

  task automatic run_layer(input int n_in, input int n_out, input int in_off,
                           input int out_off, input int net_off,
                           input bit bias_en, input bit relu_en);
    logic [`BWIDTH-1:0] status;
    logic [`DWIDTH-1:0] got;
    logic [`DWIDTH-1:0] exp;
    int                 row_base;
    reg_write(`REG_IN_OFFSET, 32'(in_off));
    reg_write(`REG_OUT_OFFSET, 32'(out_off));
    reg_write(`REG_NET_OFFSET, 32'(net_off));
    reg_write(`REG_BASE, 32'((n_out << 16) | n_in));
    reg_write(`REG_ACTV, {relu_en, bias_en, 30'b0});
    reg_write(`REG_REQ, 32'h1);
    next_slot();
    // Busy set and the old done cleared
    reg_read(`REG_STATUS, status);
    check_value("status", 32'h2, status);
    wait_done();
    for (int o = 0; o < n_out; o++) begin
      row_base = net_off + o * (n_in + int'(bias_en));
      exp = model_output(n_in, in_off, row_base, bias_en, relu_en);
      img_model[out_off + o] = exp;
      mem_read(1'b0, out_off + o, got);
      check_value("mem_rdata", 32'(exp), 32'(got));
    end
  endtask

  //========================================
  // Test sequence
  //========================================
  initial begin
    logic [`BWIDTH-1:0] rd;
    logic [`DWIDTH-1:0] md;
    int                 w;
    host_reg = '0;
    host_mem = '0;
    xrst     = 1'b0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    xrst = 1'b1;

    // After reset
    reg_read(`REG_STATUS, rd);
    check_value("status", 32'h0, rd);
    repeat (4) next_slot();

    // Register readback
    reg_write(`REG_IN_OFFSET, 32'h155);
    reg_write(`REG_OUT_OFFSET, 32'h2aa);
    reg_write(`REG_NET_OFFSET, 32'h0f3);
    reg_write(`REG_BASE, 32'ha5c3_7e19);
    reg_write(`REG_ACTV, 32'hc000_0000);
    reg_read(`REG_IN_OFFSET, rd);
    check_value("reg_rdata", 32'h155, rd);
    reg_read(`REG_OUT_OFFSET, rd);
    check_value("reg_rdata", 32'h2aa, rd);
    reg_read(`REG_NET_OFFSET, rd);
    check_value("reg_rdata", 32'h0f3, rd);
    reg_read(`REG_BASE, rd);
    check_value("reg_rdata", 32'ha5c3_7e19, rd);
    reg_read(`REG_ACTV, rd);
    check_value("reg_rdata", 32'hc000_0000, rd);
    mem_write(1'b1, 5, 16'h1234);
    mem_read(1'b1, 5, md);
    check_value("mem_rdata", 32'h0, 32'(md));

    // Plain layer
    for (int i = 0; i < A_IN; i++) begin
      mem_write(1'b0, A_IOFF + i, `DWIDTH'(rand_range(-512, 511)));
    end
    for (int i = 0; i < A_IN * A_OUT; i++) begin
      mem_write(1'b1, A_NOFF + i, `DWIDTH'(rand_range(-512, 511)));
    end
    run_layer(A_IN, A_OUT, A_IOFF, A_OOFF, A_NOFF, 1'b0, 1'b0);

    // Bias and ReLU with row 0 saturating high and row 1 clipped to zero
    for (int i = 0; i < B_IN; i++) begin
      mem_write(1'b0, B_IOFF + i, `DWIDTH'(rand_range(64, 1023)));
    end
    for (int o = 0; o < B_OUT; o++) begin
      for (int i = 0; i <= B_IN; i++) begin
        if (i == B_IN) w = rand_range(-2048, 2047);
        else if (o == 0) w = 32000;
        else if (o == 1) w = -32000;
        else w = rand_range(-256, 255);
        mem_write(1'b1, B_NOFF + o * (B_IN + 1) + i, `DWIDTH'(w));
      end
    end
    run_layer(B_IN, B_OUT, B_IOFF, B_OOFF, B_NOFF, 1'b1, 1'b1);
    mem_read(1'b0, B_OOFF, md);
    check_value("mem_rdata", 32'h7fff, 32'(md));
    mem_read(1'b0, B_OOFF + 1, md);
    check_value("mem_rdata", 32'h0, 32'(md));

    // Second run on new offsets while done is still set
    for (int i = 0; i < A_IN * C_OUT; i++) begin
      mem_write(1'b1, C_NOFF + i, `DWIDTH'(rand_range(-512, 511)));
    end
    run_layer(A_IN, C_OUT, A_IOFF, C_OOFF, C_NOFF, 1'b0, 1'b0);
    verify_area(A_IOFF, A_IN);
    verify_area(A_OOFF, A_OUT);
    verify_area(B_IOFF, B_IN);
    verify_area(B_OOFF, B_OUT);

    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 2 * CLK_HALF);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/fc_accel_pkg.sv
hw/param_regs.sv
hw/img_buf.sv
hw/net_mem.sv
hw/fc_ctrl.sv
hw/fc_mac.sv
hw/fc_accel_top.sv
test/tb_fc_accel.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_fc_accel
RTL_TOP    := fc_accel_top
FLIST      := list.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
BUILD      := obj_dir
LOG        := sim.log
FAIL_MSG   := RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
